// File: logic/freq_meter_pkg.sv
// freq meter package
// shared sizes and the result record for the two-channel
// frequency and duty-cycle meter

package freq_meter_pkg;

    // number of measured square-wave inputs
    localparam int num_channels  = 2;

    // period and high accumulators
    localparam int cnt_width     = 32;   // wraps modulo 2^32

    // periods-per-window setting
    localparam int n_width       = 16;

    // channel tag carried in each result
    localparam int chan_id_width = 1;

    // one finished measurement window, 81 bits
    typedef struct packed {
        logic [chan_id_width-1:0] chan_id;        // source channel
        logic [n_width-1:0]       periods;        // periods in window, 0 already mapped to 1
        logic [cnt_width-1:0]     period_cycles;  // pll_clk cycles edge to edge
        logic [cnt_width-1:0]     high_cycles;    // cycles with input high
    } meas_result_t;

endpackage

// File: logic/period_channel.sv
// period channel
// synchronises one square wave, finds rising edges and counts
// pll_clk cycles over a window of cycles_n periods,
// then offers the result on a valid/ready link
module period_channel #(
    parameter int chan_index = 0
) (
    input  logic                               pll_clk,
    input  logic                               sys_rst_n,
    input  logic                               wave,
    input  logic [freq_meter_pkg::n_width-1:0] cycles_n,
    output freq_meter_pkg::meas_result_t       res,
    output logic                               res_valid,
    input  logic                               res_ready
);
    import freq_meter_pkg::*;

    typedef enum logic [1:0] {
        st_arm,     // waiting for first rising edge
        st_count,   // window running
        st_hold     // result stalled, edges ignored
    } state_t;

    state_t               state;

    logic                 wave_ff1;     // synchroniser stage 1
    logic                 wave_ff2;     // synchronised level
    logic                 wave_dly;     // delayed copy for edge detect
    logic                 rise;

    logic [n_width-1:0]   n_eff;        // cycles_n with 0 mapped to 1
    logic [n_width-1:0]   n_used;       // sampled at window start
    logic [n_width-1:0]   edges_left;   // rising edges still to see
    logic [cnt_width-1:0] period_cnt;
    logic [cnt_width-1:0] high_cnt;
    logic                 close_win;

    // two-flop synchroniser plus one delayed copy
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wave_ff1 <= 1'b0;
            wave_ff2 <= 1'b0;
            wave_dly <= 1'b0;
        end else begin
            wave_ff1 <= wave;
            wave_ff2 <= wave_ff1;
            wave_dly <= wave_ff2;
        end
    end

    assign rise  = wave_ff2 & ~wave_dly;
    assign n_eff = (cycles_n == '0) ? n_width'(1) : cycles_n;

    // last edge of the window, only while nothing is stalled
    assign close_win = (state == st_count) && rise && (edges_left == n_width'(1))
                       && !(res_valid && !res_ready);

    // control and counters
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= st_arm;
            res_valid  <= 1'b0;
            n_used     <= '0;
            edges_left <= '0;
            period_cnt <= '0;
            high_cnt   <= '0;
        end else begin
            if (res_valid && res_ready) begin
                res_valid <= 1'b0;   // handed over
            end
            case (state)
                st_arm: begin
                    if (rise) begin
                        state      <= st_count;
                        n_used     <= n_eff;
                        edges_left <= n_eff;
                        period_cnt <= cnt_width'(1);  // edge cycle counts
                        high_cnt   <= cnt_width'(1);  // level is high on a rise
                    end
                end
                st_count: begin
                    if (res_valid && !res_ready) begin
                        // last result not taken, drop the running window
                        state <= st_hold;
                    end else if (close_win) begin
                        res_valid  <= 1'b1;
                        n_used     <= n_eff;          // closing edge opens next window
                        edges_left <= n_eff;
                        period_cnt <= cnt_width'(1);
                        high_cnt   <= cnt_width'(1);
                    end else begin
                        period_cnt <= period_cnt + 1'b1;
                        high_cnt   <= high_cnt + cnt_width'(wave_ff2);
                        if (rise) begin
                            edges_left <= edges_left - 1'b1;
                        end
                    end
                end
                st_hold: begin
                    if (res_ready) begin
                        state <= st_arm;   // re-arm after acceptance
                    end
                end
                default: state <= st_arm;
            endcase
        end
    end

    // result payload, loaded when a window closes
    always_ff @(posedge pll_clk) begin
        if (close_win) begin
            res.chan_id       <= chan_id_width'(chan_index);
            res.periods       <= n_used;
            res.period_cycles <= period_cnt;   // start edge up to closing edge
            res.high_cycles   <= high_cnt;
        end
    end

endmodule

// File: logic/result_arbiter.sv
// result arbiter
// round-robin merge of the channel results into a one-entry
// output register driving the single result stream
module result_arbiter (
    input  logic                                                 pll_clk,
    input  logic                                                 sys_rst_n,
    input  freq_meter_pkg::meas_result_t [freq_meter_pkg::num_channels-1:0] req_res,
    input  logic [freq_meter_pkg::num_channels-1:0]             req_valid,
    output logic [freq_meter_pkg::num_channels-1:0]             req_ready,
    output freq_meter_pkg::meas_result_t                        res,
    output logic                                                 res_valid,
    input  logic                                                 res_ready
);
    import freq_meter_pkg::*;

    logic [chan_id_width-1:0] ptr;       // channel with top priority
    logic [chan_id_width-1:0] gnt_idx;
    logic [num_channels-1:0]  grant;
    logic                     slot_free; // register empty or draining

    assign slot_free = !res_valid || res_ready;

    // a channel is ready when no channel ahead of it in rotation is valid
    // its own valid is never looked at
    always_comb begin
        int  dist_i;
        int  dist_k;
        logic blocked;
        req_ready = '0;
        for (int i = 0; i < num_channels; i++) begin
            blocked = 1'b0;
            dist_i  = (i - int'(ptr) + num_channels) % num_channels;
            for (int k = 0; k < num_channels; k++) begin
                dist_k = (k - int'(ptr) + num_channels) % num_channels;
                if (k != i && dist_k < dist_i && req_valid[k]) begin
                    blocked = 1'b1;   // someone ahead wants the slot
                end
            end
            req_ready[i] = slot_free && !blocked;
        end
    end

    assign grant = req_ready & req_valid;   // one-hot or zero

    // index of the granted channel
    always_comb begin
        gnt_idx = '0;
        for (int i = 0; i < num_channels; i++) begin
            if (grant[i]) begin
                gnt_idx = chan_id_width'(i);
            end
        end
    end

    // valid flag and priority pointer
    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            res_valid <= 1'b0;
            ptr       <= '0;            // channel 0 first
        end else begin
            if (slot_free) begin
                res_valid <= |grant;
            end
            if (|grant) begin
                // move past the winner
                if (int'(gnt_idx) == num_channels - 1) begin
                    ptr <= '0;
                end else begin
                    ptr <= gnt_idx + 1'b1;
                end
            end
        end
    end

    // output payload
    always_ff @(posedge pll_clk) begin
        if (|grant) begin
            res <= req_res[gnt_idx];
        end
    end

endmodule

// File: logic/freq_duty_meter.sv
// freq duty meter top
// two period channels sharing one result stream
// through a round-robin arbiter
module freq_duty_meter (
    input  logic                                    pll_clk,
    input  logic                                    sys_rst_n,
    input  logic [freq_meter_pkg::num_channels-1:0] wave_in,
    input  logic [freq_meter_pkg::n_width-1:0]      cycles_n,
    output freq_meter_pkg::meas_result_t            res,
    output logic                                    res_valid,
    input  logic                                    res_ready
);
    import freq_meter_pkg::*;

    meas_result_t [num_channels-1:0] chan_res;    // per-channel results
    logic [num_channels-1:0]         chan_valid;
    logic [num_channels-1:0]         chan_ready;  // from arbiter

    period_channel #(.chan_index(0)) chan_0 (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .wave      (wave_in[0]),
        .cycles_n  (cycles_n),
        .res       (chan_res[0]),
        .res_valid (chan_valid[0]),
        .res_ready (chan_ready[0])
    );

    period_channel #(.chan_index(1)) chan_1 (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .wave      (wave_in[1]),
        .cycles_n  (cycles_n),      // same window length on both
        .res       (chan_res[1]),
        .res_valid (chan_valid[1]),
        .res_ready (chan_ready[1])
    );

    result_arbiter result_arbiter_i (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .req_res   (chan_res),
        .req_valid (chan_valid),
        .req_ready (chan_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

endmodule

// File: verification/clock_gen.sv
// clock and power-on reset for the meter testbench
// pll_clk at 4 ns, sys_rst_n held low for the first 16 cycles
module clock_gen (
    output logic pll_clk,
    output logic sys_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        pll_clk = 1'b0;
        forever #2 pll_clk = ~pll_clk;   // 4 ns period
    end

    initial begin
        sys_rst_n = 1'b0;
        repeat (16) @(posedge pll_clk);
        #1 sys_rst_n = 1'b1;             // released just after an edge
    end

endmodule

// File: verification/freq_duty_meter_checker.sv
// result stream checker
// handshake and sanity properties on the meter output, bound to the top level
module freq_duty_meter_checker (
    input logic                         pll_clk,
    input logic                         sys_rst_n,
    input freq_meter_pkg::meas_result_t res,
    input logic                         res_valid,
    input logic                         res_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // assertion failures so far

    // stalled result must stay put
    hold_stable: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        (res_valid && !res_ready) |=> (res_valid && $stable(res)))
        else begin
            fail_count++;
            $error("result changed or dropped while res_ready was low");
        end

    // nothing offered while in reset
    quiet_in_reset: assert property (@(posedge pll_clk) !sys_rst_n |-> !res_valid)
        else begin
            fail_count++;
            $error("res_valid high during reset");
        end

    // high time is part of the period
    high_in_period: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        res_valid |-> (res.high_cycles <= res.period_cycles))
        else begin
            fail_count++;
            $error("high_cycles larger than period_cycles");
        end

endmodule

bind freq_duty_meter freq_duty_meter_checker res_checker_i (
    .pll_clk   (pll_clk),
    .sys_rst_n (sys_rst_n),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
);

// File: verification/freq_duty_meter_tb.sv
// frequency and duty meter testbench
// square waves on both channels, every accepted result is checked
// against counts built from the wave settings
module freq_duty_meter_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import freq_meter_pkg::*;

    logic                    pll_clk;
    logic                    por_rst_n;              // from clock_gen
    logic                    tb_rst_n;               // mid-run reset
    logic [num_channels-1:0] wave_in;
    logic [n_width-1:0]      cycles_n;
    logic                    res_ready;
    logic                    res_valid;
    meas_result_t            res;

    int           seed = 32'hb66a;
    int           wave_per  [num_channels];
    int           wave_hi   [num_channels];
    int           phase     [num_channels];
    logic         wave_on   [num_channels];
    logic         wave_idle [num_channels];          // level while off
    meas_result_t rx_q      [num_channels][$];
    int           rx_count  [num_channels];
    int           test_errs = 0;
    int           pass_cnt  = 0;
    int           fail_cnt  = 0;

    clock_gen clock_gen_i (.pll_clk(pll_clk), .sys_rst_n(por_rst_n));

    freq_duty_meter freq_duty_meter_i (
        .pll_clk   (pll_clk),
        .sys_rst_n (por_rst_n & tb_rst_n),
        .wave_in   (wave_in),
        .cycles_n  (cycles_n),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    // one clock of a square wave, high for the first cycles of each period
    task automatic square_step(input int period, input int high, inout int ph,
                               output logic lvl);
        lvl = (ph < high);
        ph  = (ph + 1) % period;
    endtask

    initial begin
        logic lvl;
        wave_in = '0;
        forever begin
            @(posedge pll_clk);
            #1;
            for (int ch = 0; ch < num_channels; ch++) begin
                if (wave_on[ch]) begin
                    square_step(wave_per[ch], wave_hi[ch], phase[ch], lvl);
                end else begin
                    phase[ch] = 0;             // restart on a rising edge
                    lvl       = wave_idle[ch];
                end
                wave_in[ch] = lvl;
            end
        end
    end

    // expected counts for n whole periods
    function automatic meas_result_t expected_result(input int ch, input int period,
                                                     input int high,
                                                     input logic [n_width-1:0] n);
        meas_result_t r;
        int unsigned  n_eff;
        n_eff           = (n == '0) ? 1 : n;     // 0 means one period
        r.chan_id       = chan_id_width'(ch);
        r.periods       = n_width'(n_eff);
        r.period_cycles = cnt_width'(n_eff * period);
        r.high_cycles   = cnt_width'(n_eff * high);
        return r;
    endfunction

    function automatic void check_field(input string name, input int ch,
                                        input logic [cnt_width-1:0] got,
                                        input logic [cnt_width-1:0] exp);
        assert (got === exp) else begin
            $display("Mismatch res.%s ch%0d: got 0x%h expected 0x%h", name, ch, got, exp);
            test_errs++;
        end
    endfunction

    // transfers due on the coming rising edge, sorted by channel
    always @(negedge pll_clk) begin
        if (res_valid && res_ready) begin
            rx_q[res.chan_id].push_back(res);
        end
    end

    always @(posedge pll_clk) begin
        meas_result_t got;
        meas_result_t exp;
        for (int ch = 0; ch < num_channels; ch++) begin
            while (rx_q[ch].size() > 0) begin
                got = rx_q[ch].pop_front();
                exp = expected_result(ch, wave_per[ch], wave_hi[ch], cycles_n);
                check_field("periods", ch, cnt_width'(got.periods), cnt_width'(exp.periods));
                check_field("period_cycles", ch, got.period_cycles, exp.period_cycles);
                check_field("high_cycles", ch, got.high_cycles, exp.high_cycles);
                rx_count[ch]++;
            end
        end
    end

    task automatic rand_wave(output int per, output int hi);
        per = 4 + int'($unsigned($random(seed)) % 37);         // 4 to 40
        hi  = 1 + int'($unsigned($random(seed)) % (per - 1));  // 1 to per-1
    endtask

    // waves off, reset, new settings, waves on; period 0 leaves a channel idle
    task automatic start_test(input int per0, input int hi0, input int per1, input int hi1,
                              input logic [n_width-1:0] n);
        @(posedge pll_clk);
        wave_on[0] = 1'b0;
        wave_on[1] = 1'b0;
        #1;
        tb_rst_n  = 1'b0;
        res_ready = 1'b1;
        cycles_n  = n;
        repeat (16) @(posedge pll_clk);
        wave_per[0] = per0;
        wave_hi[0]  = hi0;
        wave_per[1] = per1;
        wave_hi[1]  = hi1;
        rx_count[0] = 0;
        rx_count[1] = 0;
        #1 tb_rst_n = 1'b1;
        @(posedge pll_clk);
        wave_on[0] = (per0 > 0);
        wave_on[1] = (per1 > 0);
    endtask

    task automatic wait_results(input int n0, input int n1, input int limit);
        int cyc;
        cyc = 0;
        while ((rx_count[0] < n0 || rx_count[1] < n1) && cyc < limit) begin
            @(negedge pll_clk);
            cyc++;
        end
        assert (rx_count[0] >= n0 && rx_count[1] >= n1) else begin
            $display("timeout: only %0d and %0d results after %0d cycles",
                     rx_count[0], rx_count[1], limit);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        int p0;
        int h0;
        int p1;
        int h1;
        int cyc;
        int gap;
        int run;
        int seen;
        int chk_fails;
        tb_rst_n  = 1'b1;
        cycles_n  = '0;
        res_ready = 1'b1;
        for (int ch = 0; ch < num_channels; ch++) begin
            wave_on[ch]   = 1'b0;
            wave_idle[ch] = 1'b0;
            wave_per[ch]  = 4;
            wave_hi[ch]   = 1;
        end
        cyc = 0;
        while (!por_rst_n && cyc < 100) begin   // power-on reset
            @(posedge pll_clk);
            cyc++;
        end
        assert (por_rst_n) else begin
            $display("power-on reset still active after %0d cycles", cyc);
            fail_cnt++;
        end

        start_test(10, 3, 0, 0, 4);
        wait_results(3, 0, 1000);
        assert (rx_count[1] == 0) else begin
            $display("channel 1 gave a result with its input held low");
            test_errs++;
        end
        finish_test("single channel");

        rand_wave(p0, h0);
        rand_wave(p1, h1);
        start_test(p0, h0, p1, h1, 8);
        wait_results(4, 4, 10000);   // both streams interleaved
        finish_test("both channels");

        rand_wave(p0, h0);
        rand_wave(p1, h1);
        start_test(p0, h0, p1, h1, 1);
        wait_results(2, 2, 1000);
        start_test(p0, h0, p1, h1, 0);   // 0 acts as 1
        wait_results(2, 2, 1000);
        finish_test("window length");

        rand_wave(p0, h0);
        rand_wave(p1, h1);
        start_test(p0, h0, p1, h1, 2);
        cyc = 0;
        while ((rx_count[0] < 3 || rx_count[1] < 3) && cyc < 40000) begin
            gap = 1 + int'($unsigned($random(seed)) % 200);   // stall stretch
            run = 1 + int'($unsigned($random(seed)) % 40);
            for (int i = 0; i < gap + run; i++) begin
                @(posedge pll_clk);
                #1;
                res_ready = (i >= gap);
            end
            cyc += gap + run;
        end
        res_ready = 1'b1;
        assert (rx_count[0] >= 3 && rx_count[1] >= 3) else begin
            $display("timeout: results stopped under back-pressure");
            test_errs++;
        end
        finish_test("back-pressure");

        wave_idle[1] = 1'b1;   // one input stuck high, the other low
        start_test(0, 0, 0, 0, 4);
        seen = 0;
        for (int i = 0; i < 2000; i++) begin
            @(posedge pll_clk);
            #1;
            if (res_valid) begin
                seen++;
            end
        end
        assert (seen == 0) else begin
            $display("res_valid was high for %0d cycles with no input edges", seen);
            test_errs++;
        end
        wave_idle[1] = 1'b0;
        finish_test("no edges");

        rand_wave(p0, h0);
        rand_wave(p1, h1);
        start_test(p0, h0, p1, h1, 8);
        wait_results(1, 0, 4000);
        repeat (3 * p0) @(posedge pll_clk);   // inside the next window
        wave_on[0] = 1'b0;
        wave_on[1] = 1'b0;
        #1 tb_rst_n = 1'b0;
        seen = 0;
        for (int i = 0; i < 16; i++) begin
            @(posedge pll_clk);
            #1;
            if (res_valid !== 1'b0) begin
                seen++;
            end
        end
        assert (seen == 0) else begin
            $display("res_valid was not low during reset");
            test_errs++;
        end
        rx_count[0] = 0;
        rx_count[1] = 0;
        tb_rst_n    = 1'b1;
        @(posedge pll_clk);
        wave_on[0] = 1'b1;
        wave_on[1] = 1'b1;
        wait_results(1, 1, 4000);   // fresh windows only
        finish_test("reset mid window");

        chk_fails = freq_duty_meter_i.res_checker_i.fail_count;
        $display("tests passed %0d, tests failed %0d, checker failures %0d",
                 pass_cnt, fail_cnt, chk_fails);
        if (fail_cnt == 0 && chk_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
logic/freq_meter_pkg.sv
logic/period_channel.sv
logic/result_arbiter.sv
logic/freq_duty_meter.sv
verification/clock_gen.sv
verification/freq_duty_meter_checker.sv
verification/freq_duty_meter_tb.sv

// File: Makefile
# Verilator build and run for the frequency and duty meter

VERILATOR ?= verilator
TOP       ?= freq_duty_meter_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
